// File: design/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// field widths
`define CSR_NUM_W       14
`define ECODE_W         6
`define ESUBCODE_W      9
`define IS_W            13
`define SW_IS_W         2
`define SAVE_CNT        4

// register numbers
`define CSR_CRMD        14'h000
`define CSR_PRMD        14'h001
`define CSR_ECFG        14'h004
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006
`define CSR_BADV        14'h007
`define CSR_EENTRY      14'h00c
`define CSR_SAVE0       14'h030
`define CSR_SAVE1       14'h031
`define CSR_SAVE2       14'h032
`define CSR_SAVE3       14'h033
`define CSR_TID         14'h040
`define CSR_TCFG        14'h041
`define CSR_TVAL        14'h042
`define CSR_TICLR       14'h044

// exception codes that load badv
`define ECODE_ADE       6'h08
`define ECODE_ALE       6'h09
`define ESUBCODE_ADEF   9'h000

// lie bit 10 is reserved
`define ECFG_LIE_MASK   13'h1bff

// timer interrupt position in estat.is
`define TIMER_IS_BIT    11

// ticlr clear bit
`define TICLR_CLR_BIT   0

// counter parks here once a one-shot count is done
`define TIMER_IDLE      32'hffff_ffff

`endif

// File: design/csr_pkg.sv
`default_nettype none

`include "csr_params.svh"

package csr_pkg;

    typedef struct packed {
        logic                   we;
        logic [`CSR_NUM_W-1:0]  num;
        logic [31:0]            wmask;
        logic [31:0]            wvalue;
    } csr_cmd_t;

    // report from the write-back stage
    typedef struct packed {
        logic                   ex;
        logic                   ertn;
        logic [`ECODE_W-1:0]    ecode;
        logic [`ESUBCODE_W-1:0] esubcode;
        logic [31:0]            vaddr;
        logic [31:0]            pc;
    } wb_exc_t;

    typedef struct packed {
        logic [1:0]                  plv;
        logic                        ie;
        logic [1:0]                  pplv;
        logic                        pie;
        logic [`IS_W-1:0]            lie;
        logic [`SW_IS_W-1:0]         sw_is;
        logic [`ECODE_W-1:0]         ecode;
        logic [`ESUBCODE_W-1:0]      esubcode;
        logic [31:0]                 era;
        logic [25:0]                 eentry_va;
        logic [31:0]                 badv;
        logic [`SAVE_CNT-1:0][31:0]  save;
    } exc_state_t;

    typedef struct packed {
        logic [31:0] tid;
        logic        en;
        logic        periodic;
        logic [29:0] initval;
        logic [31:0] cnt;
        logic        timer_is;
    } timer_state_t;

    // field layouts of one 32-bit word
    typedef struct packed {
        logic [22:0] rsvd;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_layout_t;

    typedef struct packed {
        logic [28:0] rsvd;
        logic        pie;
        logic [1:0]  pplv;
    } prmd_layout_t;

    typedef struct packed {
        logic [18:0]      rsvd;
        logic [`IS_W-1:0] lie;
    } ecfg_layout_t;

    typedef struct packed {
        logic                   rsvd_hi;
        logic [`ESUBCODE_W-1:0] esubcode;
        logic [`ECODE_W-1:0]    ecode;
        logic [2:0]             rsvd_lo;
        logic [`IS_W-1:0]       is;
    } estat_layout_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_layout_t;

    typedef union packed {
        logic [31:0]   raw;
        crmd_layout_t  crmd;
        prmd_layout_t  prmd;
        ecfg_layout_t  ecfg;
        estat_layout_t estat;
        tcfg_layout_t  tcfg;
    } csr_word_u;

endpackage

`default_nettype wire

// File: design/exception_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_params.svh"

module exception_regs (
    input  wire                  clk,
    input  wire                  reset,
    input  wire csr_pkg::csr_cmd_t cmd,
    input  wire csr_pkg::wb_exc_t  exc,
    output csr_pkg::exc_state_t  exc_state
);
    import csr_pkg::*;

    csr_word_u            set_w;
    csr_word_u            keep_w;
    logic                 we_crmd;
    logic                 we_prmd;
    logic                 we_ecfg;
    logic                 we_estat;
    logic                 we_era;
    logic                 we_badv;
    logic                 we_eentry;
    logic [`SAVE_CNT-1:0] we_save;
    logic                 addr_err;
    logic                 badv_from_pc;

    // masked bits come from set_w, the others are kept where keep_w is 1
    assign set_w.raw  = cmd.wmask & cmd.wvalue;
    assign keep_w.raw = ~cmd.wmask;

    assign we_crmd   = cmd.we && (cmd.num == `CSR_CRMD);
    assign we_prmd   = cmd.we && (cmd.num == `CSR_PRMD);
    assign we_ecfg   = cmd.we && (cmd.num == `CSR_ECFG);
    assign we_estat  = cmd.we && (cmd.num == `CSR_ESTAT);
    assign we_era    = cmd.we && (cmd.num == `CSR_ERA);
    assign we_badv   = cmd.we && (cmd.num == `CSR_BADV);
    assign we_eentry = cmd.we && (cmd.num == `CSR_EENTRY);

    always_comb begin
        for (int i = 0; i < `SAVE_CNT; i++) begin
            we_save[i] = cmd.we && (cmd.num == `CSR_NUM_W'(`CSR_SAVE0 + i));
        end
    end

    // only address errors record a bad address
    assign addr_err     = (exc.ecode == `ECODE_ADE) || (exc.ecode == `ECODE_ALE);
    assign badv_from_pc = (exc.ecode == `ECODE_ADE) && (exc.esubcode == `ESUBCODE_ADEF);

    always_ff @(posedge clk) begin
        if (reset) begin
            exc_state <= '0;
        end else begin
            // crmd takes exception first, then ertn, then write
            if (exc.ex) begin
                exc_state.plv <= 2'b00;
                exc_state.ie  <= 1'b0;
            end else if (exc.ertn) begin
                exc_state.plv <= exc_state.pplv;
                exc_state.ie  <= exc_state.pie;
            end else if (we_crmd) begin
                exc_state.plv <= set_w.crmd.plv | (keep_w.crmd.plv & exc_state.plv);
                exc_state.ie  <= set_w.crmd.ie | (keep_w.crmd.ie & exc_state.ie);
            end

            // prmd saves the mode on entry
            if (exc.ex) begin
                exc_state.pplv <= exc_state.plv;
                exc_state.pie  <= exc_state.ie;
            end else if (we_prmd) begin
                exc_state.pplv <= set_w.prmd.pplv | (keep_w.prmd.pplv & exc_state.pplv);
                exc_state.pie  <= set_w.prmd.pie | (keep_w.prmd.pie & exc_state.pie);
            end

            if (we_ecfg) begin
                exc_state.lie <= (set_w.ecfg.lie | (keep_w.ecfg.lie & exc_state.lie))
                               & `ECFG_LIE_MASK;
            end

            // software interrupt bits only
            if (we_estat) begin
                exc_state.sw_is <= set_w.estat.is[`SW_IS_W-1:0]
                                 | (keep_w.estat.is[`SW_IS_W-1:0] & exc_state.sw_is);
            end

            if (exc.ex) begin
                exc_state.ecode    <= exc.ecode;
                exc_state.esubcode <= exc.esubcode;
            end

            if (exc.ex) begin
                exc_state.era <= exc.pc;
            end else if (we_era) begin
                exc_state.era <= set_w.raw | (keep_w.raw & exc_state.era);
            end

            // fetch errors report the pc itself
            if (exc.ex && addr_err) begin
                exc_state.badv <= badv_from_pc ? exc.pc : exc.vaddr;
            end else if (we_badv) begin
                exc_state.badv <= set_w.raw | (keep_w.raw & exc_state.badv);
            end

            if (we_eentry) begin
                exc_state.eentry_va <= set_w.raw[31:6] | (keep_w.raw[31:6] & exc_state.eentry_va);
            end

            for (int i = 0; i < `SAVE_CNT; i++) begin
                if (we_save[i]) begin
                    exc_state.save[i] <= set_w.raw | (keep_w.raw & exc_state.save[i]);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/stable_timer.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_params.svh"

module stable_timer (
    input  wire                    clk,
    input  wire                    reset,
    input  wire csr_pkg::csr_cmd_t cmd,
    output csr_pkg::timer_state_t  tmr_state
);
    import csr_pkg::*;

    csr_word_u set_w;
    csr_word_u keep_w;
    csr_word_u tcfg_cur;
    csr_word_u tcfg_next;
    logic      we_tid;
    logic      we_tcfg;
    logic      clr_req;
    logic      cnt_zero;
    logic      cnt_idle;

    assign set_w.raw  = cmd.wmask & cmd.wvalue;
    assign keep_w.raw = ~cmd.wmask;

    assign we_tid  = cmd.we && (cmd.num == `CSR_TID);
    assign we_tcfg = cmd.we && (cmd.num == `CSR_TCFG);
    assign clr_req = cmd.we && (cmd.num == `CSR_TICLR) && set_w.raw[`TICLR_CLR_BIT];

    // tcfg as it will be after this edge, so a write can start the count at once
    assign tcfg_cur.raw  = {tmr_state.initval, tmr_state.periodic, tmr_state.en};
    assign tcfg_next.raw = we_tcfg ? (set_w.raw | (keep_w.raw & tcfg_cur.raw)) : tcfg_cur.raw;

    assign cnt_zero = (tmr_state.cnt == 32'h0);
    assign cnt_idle = (tmr_state.cnt == `TIMER_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            tmr_state.tid      <= 32'h0;
            tmr_state.en       <= 1'b0;
            tmr_state.periodic <= 1'b0;
            tmr_state.initval  <= 30'h0;
            tmr_state.cnt      <= `TIMER_IDLE;
            tmr_state.timer_is <= 1'b0;
        end else begin
            if (we_tid) begin
                tmr_state.tid <= set_w.raw | (keep_w.raw & tmr_state.tid);
            end

            tmr_state.en       <= tcfg_next.tcfg.en;
            tmr_state.periodic <= tcfg_next.tcfg.periodic;
            tmr_state.initval  <= tcfg_next.tcfg.initval;

            // count is initval times four
            if (we_tcfg && tcfg_next.tcfg.en) begin
                tmr_state.cnt <= {tcfg_next.tcfg.initval, 2'b00};
            end else if (tmr_state.en && !cnt_idle) begin
                if (cnt_zero && tmr_state.periodic) begin
                    tmr_state.cnt <= {tmr_state.initval, 2'b00};
                end else begin
                    // one-shot wraps from zero to idle and parks
                    tmr_state.cnt <= tmr_state.cnt - 32'd1;
                end
            end

            // set beats clear
            if (cnt_zero) begin
                tmr_state.timer_is <= 1'b1;
            end else if (clr_req) begin
                tmr_state.timer_is <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/csr_readout.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_params.svh"

module csr_readout (
    input  wire [`CSR_NUM_W-1:0]     csr_num,
    input  wire csr_pkg::exc_state_t   exc_state,
    input  wire csr_pkg::timer_state_t tmr_state,
    output logic [31:0]              rvalue,
    output logic [31:0]              ex_entry,
    output logic [31:0]              ertn_entry,
    output logic                     has_int
);
    import csr_pkg::*;

    csr_word_u        crmd_w;
    csr_word_u        prmd_w;
    csr_word_u        ecfg_w;
    csr_word_u        estat_w;
    csr_word_u        tcfg_w;
    logic [`IS_W-1:0] is_bits;

    always_comb begin
        // no hardware or inter-core interrupt lines
        is_bits                   = '0;
        is_bits[`SW_IS_W-1:0]     = exc_state.sw_is;
        is_bits[`TIMER_IS_BIT]    = tmr_state.timer_is;

        // da, pg, datf, datm stay zero
        crmd_w.raw                = '0;
        crmd_w.crmd.plv           = exc_state.plv;
        crmd_w.crmd.ie            = exc_state.ie;

        prmd_w.raw                = '0;
        prmd_w.prmd.pplv          = exc_state.pplv;
        prmd_w.prmd.pie           = exc_state.pie;

        ecfg_w.raw                = '0;
        ecfg_w.ecfg.lie           = exc_state.lie;

        estat_w.raw               = '0;
        estat_w.estat.is          = is_bits;
        estat_w.estat.ecode       = exc_state.ecode;
        estat_w.estat.esubcode    = exc_state.esubcode;

        tcfg_w.tcfg.initval       = tmr_state.initval;
        tcfg_w.tcfg.periodic      = tmr_state.periodic;
        tcfg_w.tcfg.en            = tmr_state.en;
    end

    // ticlr and unknown numbers read zero
    always_comb begin
        case (csr_num)
            `CSR_CRMD:   rvalue = crmd_w.raw;
            `CSR_PRMD:   rvalue = prmd_w.raw;
            `CSR_ECFG:   rvalue = ecfg_w.raw;
            `CSR_ESTAT:  rvalue = estat_w.raw;
            `CSR_ERA:    rvalue = exc_state.era;
            `CSR_BADV:   rvalue = exc_state.badv;
            `CSR_EENTRY: rvalue = {exc_state.eentry_va, 6'b0};
            `CSR_SAVE0:  rvalue = exc_state.save[0];
            `CSR_SAVE1:  rvalue = exc_state.save[1];
            `CSR_SAVE2:  rvalue = exc_state.save[2];
            `CSR_SAVE3:  rvalue = exc_state.save[3];
            `CSR_TID:    rvalue = tmr_state.tid;
            `CSR_TCFG:   rvalue = tcfg_w.raw;
            `CSR_TVAL:   rvalue = tmr_state.cnt;
            default:     rvalue = 32'h0;
        endcase
    end

    assign ex_entry   = {exc_state.eentry_va, 6'b0};
    assign ertn_entry = exc_state.era;

    assign has_int = exc_state.ie
                   & (|(is_bits[`TIMER_IS_BIT:0] & exc_state.lie[`TIMER_IS_BIT:0]));

endmodule

`default_nettype wire

// File: design/csr_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_params.svh"

module csr_file (
    input  wire                    clk,
    input  wire                    reset,
    input  wire csr_pkg::csr_cmd_t cmd,
    input  wire csr_pkg::wb_exc_t  exc,
    output logic [31:0]            rvalue,
    output logic [31:0]            ex_entry,
    output logic [31:0]            ertn_entry,
    output logic                   has_int
);
    import csr_pkg::*;

    exc_state_t            exc_state;
    timer_state_t          tmr_state;
    logic [`CSR_NUM_W-1:0] rd_num;

    // reads are combinational on the same register number
    assign rd_num = cmd.num;

    // both groups see every command and decode their own numbers
    exception_regs u_exception_regs (
        .clk        (clk),
        .reset      (reset),
        .cmd        (cmd),
        .exc        (exc),
        .exc_state  (exc_state)
    );

    stable_timer u_stable_timer (
        .clk        (clk),
        .reset      (reset),
        .cmd        (cmd),
        .tmr_state  (tmr_state)
    );

    csr_readout u_csr_readout (
        .csr_num    (rd_num),
        .exc_state  (exc_state),
        .tmr_state  (tmr_state),
        .rvalue     (rvalue),
        .ex_entry   (ex_entry),
        .ertn_entry (ertn_entry),
        .has_int    (has_int)
    );

endmodule

`default_nettype wire

// File: test/csr_ref_model.svh
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

// register words as last written with reserved bits masked off on read
typedef struct packed {
    logic [31:0]      crmd;
    logic [31:0]      prmd;
    logic [31:0]      ecfg;
    logic [31:0]      estat_sw;
    logic [5:0]       ecode;
    logic [8:0]       esub;
    logic [31:0]      era;
    logic [31:0]      eentry;
    logic [31:0]      badv;
    logic [3:0][31:0] save;
    logic [31:0]      tid;
    logic [31:0]      tcfg;
    logic [31:0]      cnt;
    logic             tis;
} ref_state_t;

ref_state_t ref_st;

function automatic void model_reset();
    ref_st = '0;
    ref_st.cnt = `TIMER_IDLE;
endfunction

function automatic logic [31:0] merge_bits(input logic [31:0] old, input logic [31:0] mask,
                                           input logic [31:0] val);
    return (old & ~mask) | (val & mask);
endfunction

// one clock edge from the old state in ref_st into nxt
function automatic void model_edge(input csr_cmd_t c, input wb_exc_t e);
    ref_state_t nxt;
    logic       clr;
    logic       tcfg_wr;
    nxt = ref_st;
    clr = 1'b0;
    tcfg_wr = c.we && (c.num == `CSR_TCFG);
    if (c.we) begin
        case (c.num)
            `CSR_CRMD:   nxt.crmd = merge_bits(ref_st.crmd, c.wmask, c.wvalue);
            `CSR_PRMD:   nxt.prmd = merge_bits(ref_st.prmd, c.wmask, c.wvalue);
            `CSR_ECFG:   nxt.ecfg = merge_bits(ref_st.ecfg, c.wmask, c.wvalue);
            `CSR_ESTAT:  nxt.estat_sw = merge_bits(ref_st.estat_sw, c.wmask, c.wvalue);
            `CSR_ERA:    nxt.era = merge_bits(ref_st.era, c.wmask, c.wvalue);
            `CSR_BADV:   nxt.badv = merge_bits(ref_st.badv, c.wmask, c.wvalue);
            `CSR_EENTRY: nxt.eentry = merge_bits(ref_st.eentry, c.wmask, c.wvalue);
            `CSR_SAVE0:  nxt.save[0] = merge_bits(ref_st.save[0], c.wmask, c.wvalue);
            `CSR_SAVE1:  nxt.save[1] = merge_bits(ref_st.save[1], c.wmask, c.wvalue);
            `CSR_SAVE2:  nxt.save[2] = merge_bits(ref_st.save[2], c.wmask, c.wvalue);
            `CSR_SAVE3:  nxt.save[3] = merge_bits(ref_st.save[3], c.wmask, c.wvalue);
            `CSR_TID:    nxt.tid = merge_bits(ref_st.tid, c.wmask, c.wvalue);
            `CSR_TCFG:   nxt.tcfg = merge_bits(ref_st.tcfg, c.wmask, c.wvalue);
            `CSR_TICLR:  clr = c.wmask[0] & c.wvalue[0];
            default:     ;
        endcase
    end
    // exception beats ertn, and both beat a write to the mode bits
    if (e.ex) begin
        nxt.crmd[2:0] = 3'b000;
        nxt.prmd[2:0] = ref_st.crmd[2:0];
        nxt.era = e.pc;
        nxt.ecode = e.ecode;
        nxt.esub = e.esubcode;
        if (e.ecode == `ECODE_ADE || e.ecode == `ECODE_ALE) begin
            if (e.ecode == `ECODE_ADE && e.esubcode == `ESUBCODE_ADEF) begin
                nxt.badv = e.pc;
            end else begin
                nxt.badv = e.vaddr;
            end
        end
    end else if (e.ertn) begin
        nxt.crmd[2:0] = ref_st.prmd[2:0];
    end
    if (tcfg_wr && nxt.tcfg[0]) begin
        nxt.cnt = {nxt.tcfg[31:2], 2'b00};
    end else if (ref_st.tcfg[0] && ref_st.cnt != `TIMER_IDLE) begin
        if (ref_st.cnt != 32'h0) begin
            nxt.cnt = ref_st.cnt - 32'd1;
        end else if (ref_st.tcfg[1]) begin
            nxt.cnt = {ref_st.tcfg[31:2], 2'b00};
        end else begin
            nxt.cnt = `TIMER_IDLE;
        end
    end
    if (ref_st.cnt == 32'h0) begin
        nxt.tis = 1'b1;
    end else if (clr) begin
        nxt.tis = 1'b0;
    end
    ref_st = nxt;
endfunction

function automatic logic [31:0] model_read(input logic [13:0] num);
    case (num)
        `CSR_CRMD:   return ref_st.crmd & 32'h7;
        `CSR_PRMD:   return ref_st.prmd & 32'h7;
        `CSR_ECFG:   return ref_st.ecfg & 32'h1bff;
        `CSR_ESTAT:  return {1'b0, ref_st.esub, ref_st.ecode, 4'b0, ref_st.tis, 9'b0,
                             ref_st.estat_sw[1:0]};
        `CSR_ERA:    return ref_st.era;
        `CSR_BADV:   return ref_st.badv;
        `CSR_EENTRY: return ref_st.eentry & 32'hffff_ffc0;
        `CSR_SAVE0:  return ref_st.save[0];
        `CSR_SAVE1:  return ref_st.save[1];
        `CSR_SAVE2:  return ref_st.save[2];
        `CSR_SAVE3:  return ref_st.save[3];
        `CSR_TID:    return ref_st.tid;
        `CSR_TCFG:   return ref_st.tcfg;
        `CSR_TVAL:   return ref_st.cnt;
        default:     return 32'h0;
    endcase
endfunction

function automatic logic model_has_int();
    return ref_st.crmd[2] && (|({ref_st.tis, 9'b0, ref_st.estat_sw[1:0]} & ref_st.ecfg[11:0]));
endfunction

`endif

// File: test/tb_csr_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_params.svh"

module tb_csr_file;
    import csr_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int WR_ROUNDS    = 48;
    localparam int EXC_ROUNDS   = 12;
    localparam int RET_ROUNDS   = 8;
    localparam int INT_ROUNDS   = 40;
    // worst case cycles of each test
    localparam int T1_CYCLES = WR_ROUNDS * 2;
    localparam int T2_CYCLES = 2 + EXC_ROUNDS * 7;
    localparam int T3_CYCLES = RET_ROUNDS * 6;
    localparam int T4_CYCLES = 3 + 8 * 4 + 8 + 3;
    localparam int T5_CYCLES = 2 + 3 * (4 * 4 + 1) + 3 + 2;
    localparam int T6_CYCLES = 1 + INT_ROUNDS * 2;
    localparam int WATCHDOG_NS = (RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES
                                  + T5_CYCLES + T6_CYCLES) * CLK_PERIOD * 2 + 200;

    logic        clk;
    logic        reset;
    csr_cmd_t    cmd;
    wb_exc_t     exc;
    logic [31:0] rvalue;
    logic [31:0] ex_entry;
    logic [31:0] ertn_entry;
    logic        has_int;
    logic [31:0] lfsr;
    string       cur_test;
    int          test_errors;
    int          checks;
    int          passed;
    int          failed;

    `include "csr_ref_model.svh"

    csr_file UUT (
        .clk        (clk),
        .reset      (reset),
        .cmd        (cmd),
        .exc        (exc),
        .rvalue     (rvalue),
        .ex_entry   (ex_entry),
        .ertn_entry (ertn_entry),
        .has_int    (has_int)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic out;
        out = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], next_bit()};
        end
        return r;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Error: %s %s expected %h actual %h", cur_test, what, expected, actual);
            test_errors++;
        end
    endtask

    // model steps with the inputs held for this edge
    task automatic next_cycle();
        model_edge(cmd, exc);
        @(posedge clk);
        #1;
        cmd.we = 1'b0;
        exc.ex = 1'b0;
        exc.ertn = 1'b0;
    endtask

    task automatic write_csr(input logic [13:0] num, input logic [31:0] mask,
                             input logic [31:0] val);
        cmd.we = 1'b1;
        cmd.num = num;
        cmd.wmask = mask;
        cmd.wvalue = val;
        next_cycle();
    endtask

    task automatic read_and_check(input logic [13:0] num);
        cmd.we = 1'b0;
        cmd.num = num;
        #2;
        check_value($sformatf("csr %h", num), model_read(num), rvalue);
        check_value("has_int", {31'b0, model_has_int()}, {31'b0, has_int});
        check_value("ex_entry", model_read(`CSR_EENTRY), ex_entry);
        check_value("ertn_entry", model_read(`CSR_ERA), ertn_entry);
        next_cycle();
    endtask

    task automatic raise_exception(input logic [5:0] ecode, input logic [8:0] esub);
        exc.ex = 1'b1;
        exc.ecode = ecode;
        exc.esubcode = esub;
        exc.vaddr = rand_bits(32);
        exc.pc = rand_bits(32);
        next_cycle();
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            passed++;
            $display("test %s: ok", cur_test);
        end else begin
            failed++;
            $display("test %s: %0d errors", cur_test, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic test_masked_write();
        logic [13:0] nums [10];
        logic [13:0] num;
        logic [31:0] mask;
        nums = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_ERA, `CSR_EENTRY,
                 `CSR_TID, `CSR_PRMD, `CSR_ECFG, `CSR_BADV};
        cur_test = "masked_write";
        for (int i = 0; i < WR_ROUNDS; i++) begin
            num = nums[rand_bits(4) % 10];
            mask = rand_bits(32);
            write_csr(num, mask, rand_bits(32));
            read_and_check(num);
        end
        end_test();
    endtask

    task automatic test_exception_entry();
        logic [31:0] r;
        logic [5:0]  ecode;
        logic [8:0]  esub;
        cur_test = "exception_entry";
        write_csr(`CSR_EENTRY, 32'hffff_ffff, rand_bits(32));
        read_and_check(`CSR_EENTRY);
        for (int i = 0; i < EXC_ROUNDS; i++) begin
            r = rand_bits(2);
            write_csr(`CSR_CRMD, 32'h7, {29'b0, 1'b1, r[1:0]});
            r = rand_bits(2);
            if (r == 0) begin
                ecode = `ECODE_ADE;
                esub = rand_bits(1) ? 9'h001 : `ESUBCODE_ADEF;
            end else begin
                ecode = (r == 1) ? `ECODE_ALE : 6'(rand_bits(6));
                esub = 9'(rand_bits(9));
            end
            raise_exception(ecode, esub);
            read_and_check(`CSR_CRMD);
            read_and_check(`CSR_PRMD);
            read_and_check(`CSR_ERA);
            read_and_check(`CSR_ESTAT);
            read_and_check(`CSR_BADV);
        end
        end_test();
    endtask

    task automatic test_return();
        logic [31:0] r;
        cur_test = "return";
        for (int i = 0; i < RET_ROUNDS; i++) begin
            r = rand_bits(3);
            write_csr(`CSR_CRMD, 32'h7, r);
            raise_exception(6'(rand_bits(6)), 9'(rand_bits(9)));
            r = rand_bits(3);
            write_csr(`CSR_PRMD, 32'h7, r);
            exc.ertn = 1'b1;
            next_cycle();
            read_and_check(`CSR_CRMD);
            read_and_check(`CSR_PRMD);
        end
        end_test();
    endtask

    task automatic test_one_shot();
        logic [31:0] init;
        cur_test = "one_shot_timer";
        write_csr(`CSR_ECFG, 32'h1fff, 32'h0800);
        write_csr(`CSR_CRMD, 32'h4, 32'h4);
        init = rand_bits(3) + 1;
        write_csr(`CSR_TCFG, 32'hffff_ffff, {init[29:0], 2'b01});
        for (int k = 0; k < init * 4 + 8; k++) begin
            read_and_check((k % 2) ? `CSR_ESTAT : `CSR_TVAL);
        end
        write_csr(`CSR_TICLR, 32'h1, 32'h1);
        read_and_check(`CSR_ESTAT);
        read_and_check(`CSR_TVAL);
        end_test();
    endtask

    task automatic test_periodic();
        logic [31:0] init;
        cur_test = "periodic_timer";
        init = rand_bits(2) + 1;
        write_csr(`CSR_TCFG, 32'hffff_ffff, {init[29:0], 2'b11});
        read_and_check(`CSR_TCFG);
        for (int k = 0; k < 3 * (init * 4 + 1) + 3; k++) begin
            case (k % 3)
                0:       read_and_check(`CSR_TVAL);
                1:       read_and_check(`CSR_ESTAT);
                default: write_csr(`CSR_TICLR, 32'h1, 32'h1);
            endcase
        end
        write_csr(`CSR_TCFG, 32'hffff_ffff, 32'h0);
        read_and_check(`CSR_TVAL);
        end_test();
    endtask

    task automatic test_interrupt();
        logic [31:0] r;
        cur_test = "interrupt_pending";
        write_csr(`CSR_TCFG, 32'hffff_ffff, 32'h5);
        for (int i = 0; i < INT_ROUNDS; i++) begin
            r = rand_bits(2);
            case (r)
                0:       write_csr(`CSR_ECFG, 32'hffff_ffff, rand_bits(32));
                1:       write_csr(`CSR_ESTAT, 32'h3, rand_bits(2));
                2:       write_csr(`CSR_CRMD, 32'h4, rand_bits(3));
                default: begin
                    if (rand_bits(1)) begin
                        write_csr(`CSR_TICLR, 32'h1, 32'h1);
                    end else begin
                        write_csr(`CSR_TCFG, 32'hffff_ffff, 32'h5);
                    end
                end
            endcase
            read_and_check(`CSR_ESTAT);
        end
        end_test();
    endtask

    initial begin
        lfsr = 32'd67;
        reset = 1'b1;
        cmd = '0;
        exc = '0;
        test_errors = 0;
        checks = 0;
        passed = 0;
        failed = 0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        test_masked_write();
        test_exception_entry();
        test_return();
        test_one_shot();
        test_periodic();
        test_interrupt();
        $display("%0d tests passed, %0d failed, %0d checks", passed, failed, checks);
        if (failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Error: watchdog expired before the tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
+incdir+test
design/csr_pkg.sv
design/exception_regs.sv
design/stable_timer.sv
design/csr_readout.sv
design/csr_file.sv
test/tb_csr_file.sv
